/* source/cromPkg.sv */
`include "dpm_params.svh"

package cromPkg;

   ////////////////////
   // Microword field encodings
   ////////////////////

   // DBM source select
   typedef enum logic [2:0]
   {
      SCADPFAPR = 3'd0,
      BYTES     = 3'd1,
      EXPTIME   = 3'd2,
      DP        = 3'd3,
      DPSWAP    = 3'd4,
      VMA       = 3'd5,
      MEM       = 3'd6,
      NUM       = 3'd7
   } dbmSelE;

   // Byte insert position for the DP select
   // Codes 6 and 7 act as NONE
   typedef enum logic [2:0]
   {
      NONE  = 3'd0,
      BYTE1 = 3'd1,
      BYTE2 = 3'd2,
      BYTE3 = 3'd3,
      BYTE4 = 3'd4,
      BYTE5 = 3'd5
   } selByteE;

   // SCAD function, A side is FE and B side is the scadB field
   typedef enum logic [2:0]
   {
      PASS_A = 3'd0,
      PASS_B = 3'd1,
      ADD    = 3'd2,
      SUB    = 3'd3,
      OR     = 3'd4,
      AND    = 3'd5
   } scadOpE;

   ////////////////////
   // Microword as seen by this slice
   ////////////////////

   typedef struct packed
   {
      dbmSelE                 dbmSel;
      selByteE                selByte;
      logic [0:`NUM_WIDTH-1]  num;
      scadOpE                 scadOp;
      logic [0:`SCAD_WIDTH-1] scadB;
      // Register load strobes, qualified by step
      logic                   loadFe;
      logic                   loadVma;
      logic                   loadApr;
      logic                   loadTimer;
   } cromWordT;

endpackage

/* source/dataPkg.sv */
`include "dpm_params.svh"

package dataPkg;

   ////////////////////
   // Data path types
   ////////////////////

   // Full word, bit 0 is the MSB
   typedef logic [0:`WORD_WIDTH-1] wordT;

   // APR flags as they sit in word bits 22 to 35
   typedef logic [0:`APR_WIDTH-1] aprFlagsT;

   // Page fail dispatch code
   typedef logic [0:`PF_WIDTH-1] pfCodeT;

   ////////////////////
   // Page fail input
   ////////////////////

   // Code is only meaningful while valid is high
   typedef struct packed
   {
      pfCodeT code;
      logic   valid;
   } pageFailT;

endpackage

/* source/dbmMux.sv */
`include "dpm_params.svh"

module dbmMux
(
   input  cromPkg::cromWordT        crom,
   input  dataPkg::wordT            dp,
   input  logic [0:`SCAD_WIDTH-1]   scad,
   input  dataPkg::pfCodeT          pfCode,
   input  dataPkg::aprFlagsT        aprFlags,
   input  logic [0:`TIMER_WIDTH-1]  timerCount,
   input  dataPkg::wordT            vma,
   input  dataPkg::wordT            memData,
   output dataPkg::wordT            dbm
);
   import cromPkg::*;

   // Seven bit byte taken from the SCAD
   logic [0:6] scadByte;

   assign scadByte = scad[1:7];

   ////////////////////
   // DBM bus select
   ////////////////////

   always_comb
   begin
      case (crom.dbmSel)
         // SCAD, ones fill, page fail code and APR flags
         SCADPFAPR:
         begin
            dbm = {scad[1:9], 8'hff, scad[0], pfCode, aprFlags};
         end
         // Byte replicated across the word
         BYTES:
         begin
            dbm = {scadByte, scadByte, scadByte, scadByte, scadByte, dp[35]};
         end
         // Exponent with timer in right half
         EXPTIME:
         begin
            dbm = {1'b0, scad[2:9], dp[9:17], timerCount};
         end
         DP:
         begin
            // Byte insert into the data path
            case (crom.selByte)
               BYTE1:
               begin
                  dbm = {scadByte, dp[7:35]};
               end
               BYTE2:
               begin
                  dbm = {dp[0:6], scadByte, dp[14:35]};
               end
               BYTE3:
               begin
                  dbm = {dp[0:13], scadByte, dp[21:35]};
               end
               BYTE4:
               begin
                  dbm = {dp[0:20], scadByte, dp[28:35]};
               end
               // Fifth byte comes out alone, rest zero
               BYTE5:
               begin
                  dbm = {28'b0, scadByte, 1'b0};
               end
               default:
               begin
                  dbm = dp;
               end
            endcase
         end
         // Swap left and right halves
         DPSWAP:
         begin
            dbm = {dp[18:35], dp[0:17]};
         end
         VMA:
         begin
            dbm = vma;
         end
         MEM:
         begin
            dbm = memData;
         end
         // number field in both halves
         default:
         begin
            dbm = {crom.num, crom.num};
         end
      endcase
   end

endmodule

/* source/dpmSlice.sv */
`include "dpm_params.svh"

module dpmSlice
(
   input  logic                  clk,
   input  logic                  rstN,
   input  logic                  step,
   input  cromPkg::cromWordT     crom,
   input  dataPkg::wordT         dp,
   input  dataPkg::wordT         memData,
   input  dataPkg::pageFailT     pageFail,
   output dataPkg::wordT         dbm,
   output logic                  dbmValid
);
   import dataPkg::*;

   // Sources into the bus mux
   logic [0:`SCAD_WIDTH-1]  scad;
   logic [0:`TIMER_WIDTH-1] timerCount;
   wordT                    vma;
   aprFlagsT                aprFlags;
   pfCodeT                  pfCode;

   // Combinational DBM before the output register
   wordT                    dbmBus;

   ////////////////////
   // Source blocks
   ////////////////////

   // Each block decodes its own load strobe
   scadUnit i_scadUnit
   (
      .clk        (clk),
      .rstN       (rstN),
      .step       (step),
      .crom       (crom),
      .scad       (scad)
   );

   intervalTimer i_intervalTimer
   (
      .clk        (clk),
      .rstN       (rstN),
      .step       (step),
      .crom       (crom),
      .dp         (dp),
      .timerCount (timerCount)
   );

   statusRegs i_statusRegs
   (
      .clk        (clk),
      .rstN       (rstN),
      .step       (step),
      .crom       (crom),
      .dp         (dp),
      .pageFail   (pageFail),
      .vma        (vma),
      .aprFlags   (aprFlags),
      .pfCode     (pfCode)
   );

   // Mux sees register values from before this edge
   dbmMux i_dbmMux
   (
      .crom       (crom),
      .dp         (dp),
      .scad       (scad),
      .pfCode     (pfCode),
      .aprFlags   (aprFlags),
      .timerCount (timerCount),
      .vma        (vma),
      .memData    (memData),
      .dbm        (dbmBus)
   );

   ////////////////////
   // Output register
   ////////////////////

   // Valid tracks step, data holds between steps
   always_ff @(posedge clk or negedge rstN)
   begin
      if (!rstN)
      begin
         dbm      <= '0;
         dbmValid <= 1'b0;
      end
      else
      begin
         dbmValid <= step;
         if (step)
         begin
            dbm <= dbmBus;
         end
      end
   end

endmodule

/* source/dpm_params.svh */
`ifndef DPM_PARAMS_SVH
`define DPM_PARAMS_SVH

// Architectural widths of the 36-bit data path
// Bit 0 is the most significant bit everywhere

// Full data path word
`define WORD_WIDTH  36

// Shift count adder and the FE register
`define SCAD_WIDTH  10

// Microword number field
`define NUM_WIDTH   18

// Interval timer, right half of a word
`define TIMER_WIDTH 18

// APR flag field, word bits 22 to 35
`define APR_WIDTH   14

// Page fail dispatch code
`define PF_WIDTH    4

`endif

/* source/intervalTimer.sv */
`include "dpm_params.svh"

module intervalTimer
(
   input  logic                     clk,
   input  logic                     rstN,
   input  logic                     step,
   input  cromPkg::cromWordT        crom,
   input  dataPkg::wordT            dp,
   output logic [0:`TIMER_WIDTH-1]  timerCount
);

   // Right half of the data path
   logic [0:`TIMER_WIDTH-1] dpRight;

   assign dpRight = dp[`WORD_WIDTH-`TIMER_WIDTH:`WORD_WIDTH-1];

   ////////////////////
   // Microcycle counter
   ////////////////////

   // One count per step, wraps past all ones
   // Load takes priority over the count
   always_ff @(posedge clk or negedge rstN)
   begin
      if (!rstN)
      begin
         timerCount <= '0;
      end
      else if (step)
      begin
         if (crom.loadTimer)
         begin
            timerCount <= dpRight;
         end
         else
         begin
            timerCount <= timerCount + 1'b1;
         end
      end
   end

endmodule

/* source/scadUnit.sv */
`include "dpm_params.svh"

module scadUnit
(
   input  logic                     clk,
   input  logic                     rstN,
   input  logic                     step,
   input  cromPkg::cromWordT        crom,
   output logic [0:`SCAD_WIDTH-1]   scad
);
   import cromPkg::*;

   // Floating exponent register, the SCAD A side
   logic [0:`SCAD_WIDTH-1] fe;

   ////////////////////
   // SCAD adder
   ////////////////////

   // Results wrap modulo 1024 by width alone
   always_comb
   begin
      case (crom.scadOp)
         PASS_A:
         begin
            scad = fe;
         end
         PASS_B:
         begin
            scad = crom.scadB;
         end
         ADD:
         begin
            scad = fe + crom.scadB;
         end
         SUB:
         begin
            scad = fe - crom.scadB;
         end
         OR:
         begin
            scad = fe | crom.scadB;
         end
         AND:
         begin
            scad = fe & crom.scadB;
         end
         // Unused codes fall back to FE
         default:
         begin
            scad = fe;
         end
      endcase
   end

   ////////////////////
   // FE register
   ////////////////////

   // Reload from the adder on a step
   always_ff @(posedge clk or negedge rstN)
   begin
      if (!rstN)
      begin
         fe <= '0;
      end
      else if (step && crom.loadFe)
      begin
         fe <= scad;
      end
   end

endmodule

/* source/statusRegs.sv */
`include "dpm_params.svh"

module statusRegs
(
   input  logic                  clk,
   input  logic                  rstN,
   input  logic                  step,
   input  cromPkg::cromWordT     crom,
   input  dataPkg::wordT         dp,
   input  dataPkg::pageFailT     pageFail,
   output dataPkg::wordT         vma,
   output dataPkg::aprFlagsT     aprFlags,
   output dataPkg::pfCodeT       pfCode
);

   // APR flag field of the data path
   logic [0:`APR_WIDTH-1] dpApr;

   assign dpApr = dp[`WORD_WIDTH-`APR_WIDTH:`WORD_WIDTH-1];

   ////////////////////
   // VMA register
   ////////////////////

   // Whole word load from the data path
   always_ff @(posedge clk or negedge rstN)
   begin
      if (!rstN)
      begin
         vma <= '0;
      end
      else if (step && crom.loadVma)
      begin
         vma <= dp;
      end
   end

   ////////////////////
   // APR flags
   ////////////////////

   // Loaded from word bits 22 to 35
   always_ff @(posedge clk or negedge rstN)
   begin
      if (!rstN)
      begin
         aprFlags <= '0;
      end
      else if (step && crom.loadApr)
      begin
         aprFlags <= dpApr;
      end
   end

   ////////////////////
   // Page fail dispatch
   ////////////////////

   // Independent of step, paging reports on any clock
   // Code holds until the next valid report
   always_ff @(posedge clk or negedge rstN)
   begin
      if (!rstN)
      begin
         pfCode <= '0;
      end
      else if (pageFail.valid)
      begin
         pfCode <= pageFail.code;
      end
   end

endmodule

/* testbench/dbmModel.svh */
`ifndef DBM_MODEL_SVH
`define DBM_MODEL_SVH

////////////////////
// SCAD prediction
////////////////////

// A side is FE, B side is the scadB field, result mod 1024
function automatic logic [0:`SCAD_WIDTH-1] predictScad
(
   input scadOpE                 op,
   input logic [0:`SCAD_WIDTH-1] fe,
   input logic [0:`SCAD_WIDTH-1] b
);
   int unsigned a;
   int unsigned bv;
   int unsigned sum;
   a  = 32'(fe);
   bv = 32'(b);
   case (op)
      PASS_B:  sum = bv;
      ADD:     sum = a + bv;
      // Borrow handled by adding the modulus first
      SUB:     sum = 1024 + a - bv;
      OR:      sum = a | bv;
      AND:     sum = a & bv;
      default: sum = a;
   endcase
   sum = sum % 1024;
   return sum[9:0];
endfunction

////////////////////
// DBM prediction
////////////////////

// Bits counted from 0 at the MSB
function automatic wordT predictDbm
(
   input cromWordT                c,
   input wordT                    d,
   input wordT                    m,
   input logic [0:`SCAD_WIDTH-1]  s,
   input pfCodeT                  pf,
   input aprFlagsT                apr,
   input logic [0:`TIMER_WIDTH-1] tmr,
   input wordT                    va
);
   wordT       w;
   logic [0:6] sb;
   int         slot;
   sb   = s[1:7];
   slot = int'(c.selByte);
   w    = '0;
   case (c.dbmSel)
      SCADPFAPR:
      begin
         w[0:8]   = s[1:9];
         w[9:16]  = 8'hff;
         w[17]    = s[0];
         w[18:21] = pf;
         w[22:35] = apr;
      end
      // Five byte copies then dp bit 35
      BYTES:   w = {{5{sb}}, d[35]};
      EXPTIME: w = {1'b0, s[2:9], d[9:17], tmr};
      DP:
      begin
         w = d;
         // Byte n sits at bits 7(n-1) up to 7n-1
         if (slot >= 1 && slot <= 4)
         begin
            w[(slot - 1) * 7 +: 7] = sb;
         end
         else if (slot == 5)
         begin
            w        = '0;
            w[28:34] = sb;
         end
      end
      DPSWAP:  w = {d[18:35], d[0:17]};
      VMA:     w = va;
      MEM:     w = m;
      // Number field in both halves
      default: w = {c.num, c.num};
   endcase
   return w;
endfunction

`endif

/* testbench/dpmSliceTb.sv */
`include "dpm_params.svh"

module dpmSliceTb;
   import cromPkg::*;
   import dataPkg::*;

   logic                    clk;
   logic                    rstN;
   logic                    step;
   cromWordT                crom;
   wordT                    dp;
   wordT                    memData;
   pageFailT                pageFail;
   wordT                    dbm;
   logic                    dbmValid;

   // Shadow copies of the slice registers
   logic [0:`SCAD_WIDTH-1]  feSh;
   logic [0:`TIMER_WIDTH-1] timerSh;
   wordT                    vmaSh;
   aprFlagsT                aprSh;
   pfCodeT                  pfSh;

   // Prediction for the step being driven and the one before
   wordT                    expDbm;
   wordT                    prevExp;
   logic                    prevStep;
   logic [31:0]             rngState;

   `include "dbmModel.svh"

   dpmSlice i_dpmSlice
   (
      .clk      (clk),
      .rstN     (rstN),
      .step     (step),
      .crom     (crom),
      .dp       (dp),
      .memData  (memData),
      .pageFail (pageFail),
      .dbm      (dbm),
      .dbmValid (dbmValid)
   );

   initial
   begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   task automatic reportFailure(input string msg);
      $display("%s", msg);
      $display("ERRORS FOUND");
      $fatal(1);
   endtask

   ////////////////////
   // Checks
   ////////////////////

   // Held at zero while reset is low
   assert property (@(negedge clk) !rstN |-> (dbm == '0 && !dbmValid))
      else reportFailure($sformatf("ERROR dbm %h dbmValid %h during reset",
                                   $sampled(dbm), $sampled(dbmValid)));

   // Valid one clock after each step and low after a cycle without one
   assert property (@(posedge clk) disable iff (!rstN) dbmValid == prevStep)
      else reportFailure($sformatf("ERROR dbmValid expected %h got %h",
                                   prevStep, $sampled(dbmValid)));

   // Output follows the latest step and holds through idle cycles
   assert property (@(posedge clk) disable iff (!rstN) dbm == prevExp)
      else reportFailure($sformatf("ERROR dbm expected %h got %h", prevExp, $sampled(dbm)));

   ////////////////////
   // Stimulus helpers
   ////////////////////

   // Xorshift32
   function automatic logic [31:0] nextRandom();
      rngState = rngState ^ (rngState << 13);
      rngState = rngState ^ (rngState >> 17);
      rngState = rngState ^ (rngState << 5);
      return rngState;
   endfunction

   function automatic wordT randomWord();
      logic [63:0] r;
      r = {nextRandom(), nextRandom()};
      return r[35:0];
   endfunction

   // Random num and scadB with all loads clear
   function automatic cromWordT makeCrom(input dbmSelE sel, input scadOpE op);
      cromWordT    c;
      logic [31:0] r;
      r        = nextRandom();
      c        = '0;
      c.dbmSel = sel;
      c.selByte = NONE;
      c.num    = r[17:0];
      c.scadOp = op;
      c.scadB  = r[27:18];
      return c;
   endfunction

   // Predict, update shadows, drive, then wait for dbmValid
   task automatic applyStep(input cromWordT c, input wordT d, input wordT m, input pageFailT pf);
      logic [0:`SCAD_WIDTH-1] s;
      int                     waitCount;
      prevStep = step;
      prevExp  = expDbm;
      s        = predictScad(c.scadOp, feSh, c.scadB);
      expDbm   = predictDbm(c, d, m, s, pfSh, aprSh, timerSh, vmaSh);
      if (c.loadFe)
         feSh = s;
      timerSh = c.loadTimer ? d[18:35] : timerSh + 18'd1;
      if (c.loadVma)
         vmaSh = d;
      if (c.loadApr)
         aprSh = d[22:35];
      if (pf.valid)
         pfSh = pf.code;
      step     = 1'b1;
      crom     = c;
      dp       = d;
      memData  = m;
      pageFail = pf;
      waitCount = 0;
      do
      begin
         @(negedge clk);
         waitCount++;
      end
      while (!dbmValid && waitCount < 4);
      if (!dbmValid)
         reportFailure("Timed out waiting for dbmValid after a step");
   endtask

   // Cycles without step with a page fail offered on the first
   task automatic idleCycles(input int n, input pageFailT pf);
      for (int i = 0; i < n; i++)
      begin
         prevStep = step;
         prevExp  = expDbm;
         if (i == 0 && pf.valid)
            pfSh = pf.code;
         step     = 1'b0;
         pageFail = (i == 0) ? pf : '0;
         @(negedge clk);
      end
   endtask

   ////////////////////
   // Test sequence
   ////////////////////

   initial
   begin
      cromWordT c;
      wordT     d;
      pageFailT pf;
      rngState = 32'hb8d7;
      {step, crom, dp, memData, pageFail} = '0;
      {feSh, timerSh, vmaSh, aprSh, pfSh} = '0;
      {expDbm, prevExp, prevStep} = '0;
      // Reset edge after time zero
      rstN = 1'b1;
      #1 rstN = 1'b0;
      repeat (16) @(negedge clk);
      rstN = 1'b1;
      assert (dbm == '0 && !dbmValid)
         else reportFailure($sformatf("ERROR dbm %h dbmValid %h after reset", dbm, dbmValid));

      // Zero registers straight out of reset
      applyStep(makeCrom(EXPTIME, PASS_A), '0, randomWord(), '0);
      applyStep(makeCrom(VMA, PASS_A), randomWord(), randomWord(), '0);

      // Forwarding selects DP through NUM in turn
      for (int i = 0; i < 16; i++)
         applyStep(makeCrom(dbmSelE'(3 + i % 5), PASS_A), randomWord(),
                   randomWord(), '0);

      // Byte insert over every selByte code
      c        = makeCrom(NUM, PASS_B);
      c.loadFe = 1'b1;
      applyStep(c, randomWord(), randomWord(), '0);
      for (int k = 0; k < 8; k++)
      begin
         c         = makeCrom(DP, PASS_A);
         c.selByte = selByteE'(k);
         applyStep(c, randomWord(), randomWord(), '0);
      end

      // Each SCAD op into FE and read back three ways
      for (int op = 0; op < 6; op++)
      begin
         c        = makeCrom(SCADPFAPR, scadOpE'(op));
         c.loadFe = 1'b1;
         applyStep(c, randomWord(), randomWord(), '0);
         applyStep(makeCrom(BYTES, PASS_A), randomWord(), randomWord(), '0);
         applyStep(makeCrom(EXPTIME, PASS_A), randomWord(), randomWord(), '0);
      end

      // VMA, APR and page fail visible only on the following step
      c         = makeCrom(VMA, PASS_A);
      c.loadVma = 1'b1;
      c.loadApr = 1'b1;
      applyStep(c, randomWord(), randomWord(), '0);
      applyStep(makeCrom(VMA, PASS_A), randomWord(), randomWord(), '0);
      pf = {4'(nextRandom()), 1'b1};
      applyStep(makeCrom(SCADPFAPR, PASS_A), randomWord(), randomWord(), pf);
      applyStep(makeCrom(SCADPFAPR, PASS_A), randomWord(), randomWord(), '0);
      pf = {4'(nextRandom()), 1'b1};
      idleCycles(2, pf);
      applyStep(makeCrom(SCADPFAPR, PASS_A), randomWord(), randomWord(), '0);

      // Timer load, count past idle cycles, wrap from all ones
      c           = makeCrom(EXPTIME, PASS_A);
      c.loadTimer = 1'b1;
      applyStep(c, randomWord(), randomWord(), '0);
      applyStep(makeCrom(EXPTIME, PASS_A), randomWord(), randomWord(), '0);
      idleCycles(3, '0);
      applyStep(makeCrom(EXPTIME, PASS_A), randomWord(), randomWord(), '0);
      d        = randomWord();
      d[18:35] = '1;
      applyStep(c, d, randomWord(), '0);
      applyStep(makeCrom(EXPTIME, PASS_A), randomWord(), randomWord(), '0);
      applyStep(makeCrom(EXPTIME, PASS_A), randomWord(), randomWord(), '0);

      // Let the last step and the idle check retire
      idleCycles(2, '0);
      $display("NO ERRORS");
      $finish;
   end

endmodule

/* verilog.f */
+incdir+source
+incdir+testbench
source/cromPkg.sv
source/dataPkg.sv
source/scadUnit.sv
source/intervalTimer.sv
source/statusRegs.sv
source/dbmMux.sv
source/dpmSlice.sv
testbench/dpmSliceTb.sv
